/* logic/smc_pkg.sv */
`default_nettype none

package smc_pkg;

  // ------------------------------
  // AHB encodings
  // ------------------------------

  // Transfer type, as on HTRANS
  typedef enum logic [1:0]
  {
    TRN_IDLE   = 2'b00,
    TRN_BUSY   = 2'b01,
    TRN_NONSEQ = 2'b10,
    TRN_SEQ    = 2'b11
  } htrans_e;

  // Transfer size; low two bits are log2 of the byte count
  typedef enum logic [2:0]
  {
    SZ_BYTE = 3'b000,
    SZ_HALF = 3'b001,
    SZ_WORD = 3'b010
  } hsize_e;

  typedef enum logic [1:0]
  {
    RSP_OKAY  = 2'b00,
    RSP_ERROR = 2'b01   // Two-cycle response
  } hresp_e;

  // ------------------------------
  // External access sequencer
  // ------------------------------
  typedef enum logic [1:0]
  {
    ST_IDLE   = 2'b00,  // No access running
    ST_SETUP  = 2'b01,  // Address and CS out
    ST_STROBE = 2'b10,  // OE or WE active
    ST_HOLD   = 2'b11   // Strobe off, data held
  } seq_state_e;

  localparam int WAIT_STATES = 2;                         // Strobe cycles per byte
  localparam int WS_CNT_W    = $clog2(WAIT_STATES + 1);   // Wait counter width

  // External SRAM bus
  localparam int EXT_ADDR_W = 16;
  localparam int EXT_DATA_W = 8;

endpackage

`default_nettype wire

/* logic/smc_ahb_lite_if.sv */
`default_nettype none
`timescale 1ns/10ps

module smc_ahb_lite_if
  import smc_pkg::*;
(
  input  wire           hclk4,          // AHB clock
  input  wire           n_sys_reset4,   // Async reset, active low
  input  wire  [31:0]   haddr,
  input  wire           hsel,           // Slave select from decoder
  input  wire  htrans_e htrans,
  input  wire           hwrite,
  input  wire  hsize_e  hsize,
  input  wire  [31:0]   hwdata,
  input  wire           hready,         // Muxed bus ready
  input  wire           smc_done,       // Last cycle of a byte access
  input  wire           mac_done,       // Last byte of the transfer
  input  wire  [31:0]   read_data,      // Assembled read data from MAC
  output logic [31:0]   smc_hrdata,
  output logic          smc_hready,
  output hresp_e        smc_hresp,
  output logic          smc_valid,      // Valid access, to system decoder
  output logic          new_access,     // Start strobe for the sequencer
  output logic [31:0]   addr,
  output logic [1:0]    xfer_size,
  output logic          n_read,         // Low for reads
  output logic [31:0]   write_data
);

  logic active;    // NONSEQ or SEQ address phase to this slave
  logic mis_err;   // Misaligned halfword or word
  logic r_ready;   // Registered part of HREADY
  logic r_hresp;   // Second error cycle still to come

  // ------------------------------
  // Address phase decode
  // ------------------------------

  // Only sampled when the bus is ready, so a held address in a stall is ignored
  assign active = hsel && hready &&
                  ((htrans == TRN_NONSEQ) || (htrans == TRN_SEQ));

  always_comb
  begin
    mis_err = 1'b0;
    if (active)
    begin
      if ((hsize == SZ_HALF) && haddr[0])
        mis_err = 1'b1;                       // Odd halfword
      else if ((hsize == SZ_WORD) && (haddr[1:0] != 2'b00))
        mis_err = 1'b1;                       // Word off a 4-byte boundary
    end
  end

  assign new_access = active && !mis_err;
  assign smc_valid  = new_access;            // Same qualifier as the start strobe

  // Attributes straight through, sequencer latches them
  assign addr      = haddr;
  assign xfer_size = hsize[1:0];
  assign n_read    = hwrite;

  // ------------------------------
  // Error response
  // ------------------------------

  // ERROR with ready low, then ERROR with ready high
  always_ff @(posedge hclk4 or negedge n_sys_reset4)
  begin
    if (!n_sys_reset4)
    begin
      smc_hresp <= RSP_OKAY;
      r_hresp   <= 1'b0;
    end
    else if (mis_err)
    begin
      smc_hresp <= RSP_ERROR;                 // First cycle
      r_hresp   <= 1'b1;
    end
    else if (r_hresp)
    begin
      smc_hresp <= RSP_ERROR;                 // Second cycle
      r_hresp   <= 1'b0;
    end
    else
    begin
      smc_hresp <= RSP_OKAY;
      r_hresp   <= 1'b0;
    end
  end

  // ------------------------------
  // Ready generation
  // ------------------------------
  always_ff @(posedge hclk4 or negedge n_sys_reset4)
  begin
    if (!n_sys_reset4)
      r_ready <= 1'b1;
    else if (mis_err)
      r_ready <= 1'b0;                        // Stall for first error cycle
    else if (r_hresp)
      r_ready <= 1'b1;                        // Release in second error cycle
    else if (new_access)
      r_ready <= 1'b0;                        // Hold data phase until done
    else if (hready)
      r_ready <= 1'b1;                        // IDLE, BUSY or not selected
  end

  // Completion of the last byte releases the stall
  assign smc_hready = r_ready || (smc_done && mac_done);

  // Data paths between AHB and the internal bus
  assign smc_hrdata = read_data;
  assign write_data = hwdata;

endmodule

`default_nettype wire

/* logic/smc_access_seq.sv */
`default_nettype none
`timescale 1ns/10ps

module smc_access_seq
  import smc_pkg::*;
(
  input  wire                   hclk4,
  input  wire                   n_sys_reset4,
  input  wire                   new_access,   // Valid address phase
  input  wire  [31:0]           addr,
  input  wire  [1:0]            xfer_size,
  input  wire                   n_read,
  input  wire  [31:0]           write_data,   // Valid in the data phase
  input  wire                   mac_done,     // Current byte is the last
  output logic                  smc_idle,
  output logic                  smc_done,     // One cycle per byte, in HOLD
  output logic                  n_cs,
  output logic                  n_oe,
  output logic                  n_we,
  output logic [EXT_ADDR_W-1:0] base_addr,
  output logic [1:0]            lat_size,
  output logic [31:0]           lat_wdata
);

  seq_state_e          state;
  seq_state_e          next_state;
  logic [WS_CNT_W-1:0] ws_cnt;        // Strobe cycles left
  logic                lat_n_read;    // Latched direction
  logic                wdata_pend;    // First SETUP of a transfer
  logic [31:0]         wdata_q;

  // ------------------------------
  // State machine
  // ------------------------------
  always_comb
  begin
    next_state = state;
    case (state)
      ST_IDLE:
        if (new_access)
          next_state = ST_SETUP;
      ST_SETUP:
        next_state = ST_STROBE;
      ST_STROBE:
        if (ws_cnt == '0)
          next_state = ST_HOLD;               // Wait states used up
      ST_HOLD:
      begin
        if (!mac_done)
          next_state = ST_SETUP;              // Next byte of the transfer
        else if (new_access)
          next_state = ST_SETUP;              // Back-to-back transfer
        else
          next_state = ST_IDLE;
      end
      default:
        next_state = ST_IDLE;
    endcase
  end

  always_ff @(posedge hclk4 or negedge n_sys_reset4)
  begin
    if (!n_sys_reset4)
      state <= ST_IDLE;
    else
      state <= next_state;
  end

  // Strobe width counter
  always_ff @(posedge hclk4 or negedge n_sys_reset4)
  begin
    if (!n_sys_reset4)
      ws_cnt <= '0;
    else if (state == ST_SETUP)
      ws_cnt <= WS_CNT_W'(WAIT_STATES - 1);
    else if ((state == ST_STROBE) && (ws_cnt != '0))
      ws_cnt <= ws_cnt - 1'b1;
  end

  // ------------------------------
  // Transfer attributes
  // ------------------------------
  always_ff @(posedge hclk4 or negedge n_sys_reset4)
  begin
    if (!n_sys_reset4)
    begin
      base_addr  <= '0;
      lat_size   <= 2'(SZ_BYTE);
      lat_n_read <= 1'b0;
    end
    else if (new_access)
    begin
      base_addr  <= addr[EXT_ADDR_W-1:0];     // Upper bits not decoded
      lat_size   <= xfer_size;
      lat_n_read <= n_read;
    end
  end

  always_ff @(posedge hclk4 or negedge n_sys_reset4)
  begin
    if (!n_sys_reset4)
      wdata_pend <= 1'b0;
    else if (new_access)
      wdata_pend <= 1'b1;
    else if (state == ST_SETUP)
      wdata_pend <= 1'b0;
  end

  // Write data captured at the end of the data phase
  always_ff @(posedge hclk4)
  begin
    if (wdata_pend && (state == ST_SETUP))
      wdata_q <= write_data;
  end

  // Bus data goes straight out in the first SETUP
  assign lat_wdata = wdata_pend ? write_data : wdata_q;

  // ------------------------------
  // Strobes and status
  // ------------------------------
  assign smc_idle = (state == ST_IDLE);
  assign smc_done = (state == ST_HOLD);
  assign n_cs     = (state == ST_IDLE);
  assign n_oe     = !(!lat_n_read && ((state == ST_STROBE) || (state == ST_HOLD)));
  assign n_we     = !(lat_n_read && (state == ST_STROBE));   // Writes only

endmodule

`default_nettype wire

/* logic/smc_mac.sv */
`default_nettype none
`timescale 1ns/10ps

module smc_mac
  import smc_pkg::*;
(
  input  wire                   hclk4,
  input  wire                   n_sys_reset4,
  input  wire                   smc_idle,     // Sequencer has nothing running
  input  wire                   smc_done,     // Byte access finishing
  input  wire  [EXT_ADDR_W-1:0] base_addr,    // Latched start address
  input  wire  [1:0]            lat_size,
  input  wire  [31:0]           lat_wdata,
  input  wire  [EXT_DATA_W-1:0] ext_rdata,
  output logic                  mac_done,     // On the last byte
  output logic [31:0]           read_data,
  output logic [EXT_ADDR_W-1:0] ext_addr,
  output logic [EXT_DATA_W-1:0] ext_wdata
);

  logic [1:0]  byte_cnt;    // Bytes completed in this transfer
  logic [1:0]  last_byte;   // Count value of the final byte
  logic [1:0]  lane;        // AHB byte lane of the current access
  logic [31:0] rd_q;        // Bytes already read

  // ------------------------------
  // Byte count
  // ------------------------------
  always_comb
  begin
    case (hsize_e'({1'b0, lat_size}))
      SZ_BYTE: last_byte = 2'd0;
      SZ_HALF: last_byte = 2'd1;
      default: last_byte = 2'd3;              // Word
    endcase
  end

  assign mac_done = (byte_cnt == last_byte);

  always_ff @(posedge hclk4 or negedge n_sys_reset4)
  begin
    if (!n_sys_reset4)
      byte_cnt <= 2'd0;
    else if (smc_idle)
      byte_cnt <= 2'd0;
    else if (smc_done)
    begin
      if (mac_done)
        byte_cnt <= 2'd0;                     // Ready for a back-to-back transfer
      else
        byte_cnt <= byte_cnt + 2'd1;
    end
  end

  // ------------------------------
  // Address and lane steering
  // ------------------------------

  // Little endian, lane follows the external address
  assign lane      = base_addr[1:0] + byte_cnt;
  assign ext_addr  = base_addr + EXT_ADDR_W'(byte_cnt);
  assign ext_wdata = lat_wdata[{lane, 3'b000} +: EXT_DATA_W];

  // ------------------------------
  // Read data assembly
  // ------------------------------
  always_ff @(posedge hclk4 or negedge n_sys_reset4)
  begin
    if (!n_sys_reset4)
      rd_q <= '0;
    else if (smc_idle)
      rd_q <= '0;
    else if (smc_done)
    begin
      if (mac_done)
        rd_q <= '0;                           // Transfer finished, start clean
      else
        rd_q[{lane, 3'b000} +: EXT_DATA_W] <= ext_rdata;
    end
  end

  // Current byte bypasses the capture register
  always_comb
  begin
    read_data = rd_q;
    read_data[{lane, 3'b000} +: EXT_DATA_W] = ext_rdata;
  end

endmodule

`default_nettype wire

/* logic/smc_top.sv */
`default_nettype none
`timescale 1ns/10ps

module smc_top
  import smc_pkg::*;
(
  input  wire                   hclk4,
  input  wire                   n_sys_reset4,
  input  wire  [31:0]           haddr,
  input  wire                   hsel,
  input  wire  htrans_e         htrans,
  input  wire                   hwrite,
  input  wire  hsize_e          hsize,
  input  wire  [31:0]           hwdata,
  input  wire                   hready,
  input  wire  [EXT_DATA_W-1:0] ext_rdata,     // From SRAM
  output logic [31:0]           smc_hrdata,
  output logic                  smc_hready,
  output hresp_e                smc_hresp,
  output logic                  smc_valid,
  output logic [EXT_ADDR_W-1:0] ext_addr,      // To SRAM
  output logic [EXT_DATA_W-1:0] ext_wdata,
  output logic                  n_cs,
  output logic                  n_oe,
  output logic                  n_we
);

  // AHB side to sequencer
  logic                  new_access;
  logic [31:0]           addr;
  logic [1:0]            xfer_size;
  logic                  n_read;
  logic [31:0]           write_data;

  // Sequencer and MAC status
  logic                  smc_done;
  logic                  smc_idle;
  logic                  mac_done;
  logic [31:0]           read_data;

  // Latched transfer
  logic [EXT_ADDR_W-1:0] base_addr;
  logic [1:0]            lat_size;
  logic [31:0]           lat_wdata;

  smc_ahb_lite_if ahb_if_i
  (
    .hclk4        (hclk4),
    .n_sys_reset4 (n_sys_reset4),
    .haddr        (haddr),
    .hsel         (hsel),
    .htrans       (htrans),
    .hwrite       (hwrite),
    .hsize        (hsize),
    .hwdata       (hwdata),
    .hready       (hready),
    .smc_done     (smc_done),
    .mac_done     (mac_done),
    .read_data    (read_data),
    .smc_hrdata   (smc_hrdata),
    .smc_hready   (smc_hready),
    .smc_hresp    (smc_hresp),
    .smc_valid    (smc_valid),
    .new_access   (new_access),
    .addr         (addr),
    .xfer_size    (xfer_size),
    .n_read       (n_read),
    .write_data   (write_data)
  );

  smc_access_seq access_seq_i
  (
    .hclk4        (hclk4),
    .n_sys_reset4 (n_sys_reset4),
    .new_access   (new_access),
    .addr         (addr),
    .xfer_size    (xfer_size),
    .n_read       (n_read),
    .write_data   (write_data),
    .mac_done     (mac_done),
    .smc_idle     (smc_idle),
    .smc_done     (smc_done),
    .n_cs         (n_cs),
    .n_oe         (n_oe),
    .n_we         (n_we),
    .base_addr    (base_addr),
    .lat_size     (lat_size),
    .lat_wdata    (lat_wdata)
  );

  smc_mac mac_i
  (
    .hclk4        (hclk4),
    .n_sys_reset4 (n_sys_reset4),
    .smc_idle     (smc_idle),
    .smc_done     (smc_done),
    .base_addr    (base_addr),
    .lat_size     (lat_size),
    .lat_wdata    (lat_wdata),
    .ext_rdata    (ext_rdata),
    .mac_done     (mac_done),
    .read_data    (read_data),
    .ext_addr     (ext_addr),
    .ext_wdata    (ext_wdata)
  );

endmodule

`default_nettype wire

/* tb/smc_checker.sv */
`default_nettype none
`timescale 1ns/10ps

module smc_checker
  import smc_pkg::*;
(
  input  wire                   hclk4,
  input  wire                   n_sys_reset4,
  input  wire  [31:0]           haddr,
  input  wire                   hsel,
  input  wire  htrans_e         htrans,
  input  wire                   hwrite,
  input  wire  hsize_e          hsize,
  input  wire  [31:0]           hwdata,
  input  wire                   exp_err,      // Entry expects an ERROR response
  input  wire  [31:0]           smc_hrdata,
  input  wire                   smc_hready,
  input  wire  hresp_e          smc_hresp,
  input  wire                   smc_valid,    // Valid access, to system decoder
  input  wire                   n_cs,
  input  wire                   n_oe,
  input  wire                   n_we,
  output int unsigned           err_cnt,
  output int unsigned           chk_cnt
);

  logic [7:0]            ref_mem [0:2**EXT_ADDR_W-1];   // Expected SRAM contents
  logic                  rst_seen;    // Post-reset pins checked
  logic                  p_acc;       // Data phase of a real transfer
  logic                  p_err;
  logic                  p_write;
  logic [EXT_ADDR_W-1:0] p_addr;
  int                    p_bytes;
  int                    p_cyc;       // Cycles spent in the data phase

  // Same pattern as the SRAM model, every address bit used
  function automatic logic [7:0] fill_byte(input logic [EXT_ADDR_W-1:0] a);
    return a[7:0] ^ {a[11:8], a[15:12]} ^ 8'h5a;
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp,
                           input logic [31:0] got);
    chk_cnt++;
    if (got !== exp)
    begin
      err_cnt++;
      $display("FAIL %s at %0t: expected %h, got %h", name, $time, exp, got);
    end
  endtask

  // ------------------------------
  // Sampling at the falling edge
  // ------------------------------
  always @(negedge hclk4)
  begin : watch
    logic [31:0]           exp_rd;
    logic [31:0]           lane_mask;
    logic [EXT_ADDR_W-1:0] a;
    if (!n_sys_reset4)
    begin
      err_cnt  = 0;
      chk_cnt  = 0;
      rst_seen = 1'b0;
      p_acc    = 1'b0;
      p_err    = 1'b0;
      for (int i = 0; i < 2**EXT_ADDR_W; i++)
        ref_mem[i] = fill_byte(EXT_ADDR_W'(i));
    end
    else
    begin
      if (!rst_seen)
      begin
        check_val("smc_hready", 32'h1, smc_hready);   // Idle bus after reset
        check_val("smc_hresp", RSP_OKAY, smc_hresp);
        check_val("n_cs", 32'h1, n_cs);
        check_val("n_oe", 32'h1, n_oe);
        check_val("n_we", 32'h1, n_we);
        rst_seen = 1'b1;
      end
      // Response during the data phase
      if (p_err)
      begin
        check_val("smc_hresp", RSP_ERROR, smc_hresp);
        check_val("smc_hready", (p_cyc != 0), smc_hready);   // Low, then high
      end
      else
        check_val("smc_hresp", RSP_OKAY, smc_hresp);
      if (!p_acc || p_err)
        check_val("n_cs", 32'h1, n_cs);                   // No SRAM cycle
      if (!p_acc)
        check_val("smc_hready", 32'h1, smc_hready);
      if (smc_hready)
      begin
        if (p_acc && !p_err)
        begin
          // Setup, wait states and hold per byte
          check_val("smc_hready latency", (2 + WAIT_STATES) * p_bytes, p_cyc + 1);
          exp_rd    = '0;
          lane_mask = '0;
          for (int k = 0; k < p_bytes; k++)
          begin
            a = p_addr + EXT_ADDR_W'(k);
            if (p_write)
              ref_mem[a] = hwdata[8 * a[1:0] +: 8];       // Little endian lane
            exp_rd[8 * a[1:0] +: 8]    = ref_mem[a];
            lane_mask[8 * a[1:0] +: 8] = 8'hff;
          end
          if (!p_write)
            check_val("smc_hrdata", exp_rd, smc_hrdata & lane_mask);
        end
        // Address phase taken at the coming edge
        p_acc   = hsel && ((htrans == TRN_NONSEQ) || (htrans == TRN_SEQ));
        p_err   = p_acc && exp_err;
        p_write = hwrite;
        p_addr  = haddr[EXT_ADDR_W-1:0];
        p_bytes = 1 << hsize[1:0];
        check_val("smc_valid", p_acc && !p_err, smc_valid);   // Aligned and selected
        p_cyc   = 0;
      end
      else
      begin
        check_val("smc_valid", 32'h0, smc_valid);   // Held address in a stall
        p_cyc++;
      end
    end
  end

endmodule

`default_nettype wire

/* tb/smc_asserts.sv */
`default_nettype none
`timescale 1ns/10ps

module smc_asserts
  import smc_pkg::*;
(
  input  wire         hclk4,
  input  wire         n_sys_reset4,
  input  wire         n_cs,
  input  wire         n_oe,
  input  wire         n_we,
  input  wire         smc_hready,
  input  wire hresp_e smc_hresp
);

  int unsigned fail_cnt = 0;   // Summed into the closing line

  // ------------------------------
  // SRAM strobes
  // ------------------------------

  // Read and write strobes never overlap
  oe_we_excl: assert property (@(posedge hclk4) disable iff (!n_sys_reset4)
                               !(!n_oe && !n_we))
    else
    begin
      $error("n_oe and n_we low in the same cycle");
      fail_cnt++;
    end

  // Any strobe only inside a chip select
  strobe_in_cs: assert property (@(posedge hclk4) disable iff (!n_sys_reset4)
                                 (!n_oe || !n_we) |-> !n_cs)
    else
    begin
      $error("n_oe or n_we low while n_cs high");
      fail_cnt++;
    end

  // Write pulse is WAIT_STATES cycles wide
  we_width: assert property (@(posedge hclk4) disable iff (!n_sys_reset4)
                             $fell(n_we) |-> !n_we [*WAIT_STATES] ##1 n_we)
    else
    begin
      $error("n_we pulse width differs from the wait state count");
      fail_cnt++;
    end

  // ------------------------------
  // AHB response
  // ------------------------------

  // First ERROR cycle, then ERROR with ready
  err_two_cycle: assert property (@(posedge hclk4) disable iff (!n_sys_reset4)
                                  ((smc_hresp == RSP_ERROR) && !smc_hready) |=>
                                  ((smc_hresp == RSP_ERROR) && smc_hready))
    else
    begin
      $error("ERROR response not followed by ERROR with smc_hready high");
      fail_cnt++;
    end

endmodule

bind smc_top smc_asserts smc_asserts_i
(
  .hclk4        (hclk4),
  .n_sys_reset4 (n_sys_reset4),
  .n_cs         (n_cs),
  .n_oe         (n_oe),
  .n_we         (n_we),
  .smc_hready   (smc_hready),
  .smc_hresp    (smc_hresp)
);

`default_nettype wire

/* tb/tb_smc.sv */
`default_nettype none
`timescale 1ns/10ps

module tb_smc
  import smc_pkg::*;
();

  localparam int READY_TIMEOUT = 100;   // Cycles, a word takes 16

  typedef struct packed
  {
    logic        sel;       // Low for a deselected entry
    htrans_e     trans;
    logic        write;
    logic [31:0] addr;
    hsize_e      size;
    logic [31:0] wdata;     // Already in its AHB lanes
    logic        exp_err;   // Misaligned, ERROR expected
  } xfer_t;

  localparam xfer_t IDLE_XFER = xfer_t'{1'b0, TRN_IDLE, 1'b0, 32'h0, SZ_BYTE, 32'h0, 1'b0};

  logic                  hclk4;
  logic                  n_sys_reset4;
  logic [31:0]           haddr;
  logic                  hsel;
  htrans_e               htrans;
  logic                  hwrite;
  hsize_e                hsize;
  logic [31:0]           hwdata;
  logic                  exp_err;
  logic [31:0]           smc_hrdata;
  logic                  smc_hready;
  hresp_e                smc_hresp;
  logic                  smc_valid;
  logic [EXT_ADDR_W-1:0] ext_addr;
  logic [EXT_DATA_W-1:0] ext_wdata;
  wire  [EXT_DATA_W-1:0] ext_rdata;
  logic                  n_cs;
  logic                  n_oe;
  logic                  n_we;
  int unsigned           err_cnt;
  int unsigned           chk_cnt;
  int                    seed;
  xfer_t                 xfer_tab [$];
  logic [7:0]            sram [0:2**EXT_ADDR_W-1];

  // Only slave on the bus, so its ready is the bus ready
  smc_top smc_top_i
  (
    .hclk4        (hclk4),
    .n_sys_reset4 (n_sys_reset4),
    .haddr        (haddr),
    .hsel         (hsel),
    .htrans       (htrans),
    .hwrite       (hwrite),
    .hsize        (hsize),
    .hwdata       (hwdata),
    .hready       (smc_hready),
    .ext_rdata    (ext_rdata),
    .smc_hrdata   (smc_hrdata),
    .smc_hready   (smc_hready),
    .smc_hresp    (smc_hresp),
    .smc_valid    (smc_valid),
    .ext_addr     (ext_addr),
    .ext_wdata    (ext_wdata),
    .n_cs         (n_cs),
    .n_oe         (n_oe),
    .n_we         (n_we)
  );

  smc_checker checker_i
  (
    .hclk4        (hclk4),
    .n_sys_reset4 (n_sys_reset4),
    .haddr        (haddr),
    .hsel         (hsel),
    .htrans       (htrans),
    .hwrite       (hwrite),
    .hsize        (hsize),
    .hwdata       (hwdata),
    .exp_err      (exp_err),
    .smc_hrdata   (smc_hrdata),
    .smc_hready   (smc_hready),
    .smc_hresp    (smc_hresp),
    .smc_valid    (smc_valid),
    .n_cs         (n_cs),
    .n_oe         (n_oe),
    .n_we         (n_we),
    .err_cnt      (err_cnt),
    .chk_cnt      (chk_cnt)
  );

  // ------------------------------
  // Asynchronous SRAM model
  // ------------------------------
  function automatic logic [7:0] fill_byte(input logic [EXT_ADDR_W-1:0] a);
    return a[7:0] ^ {a[11:8], a[15:12]} ^ 8'h5a;
  endfunction

  initial
  begin
    for (int i = 0; i < 2**EXT_ADDR_W; i++)
      sram[i] = fill_byte(EXT_ADDR_W'(i));
  end

  always @(posedge n_we)
  begin
    if (!n_cs)
      sram[ext_addr] <= ext_wdata;   // Written at the end of the strobe
  end

  assign ext_rdata = (!n_cs && !n_oe) ? sram[ext_addr] : 'z;

  initial
  begin
    hclk4 = 1'b0;
    forever #2 hclk4 = ~hclk4;
  end

  // ------------------------------
  // Transfer table
  // ------------------------------
  task automatic add_xfer(input logic sel, input htrans_e trans, input logic write,
                          input logic [31:0] addr, input hsize_e size,
                          input logic [31:0] wdata, input logic err);
    xfer_tab.push_back(xfer_t'{sel, trans, write, addr, size, wdata, err});
  endtask

  task automatic build_table();
    logic [31:0] r;
    add_xfer(1, TRN_NONSEQ, 1, 32'h100, SZ_WORD, 32'h1122_3344, 0);   // Word round trip
    add_xfer(1, TRN_NONSEQ, 0, 32'h100, SZ_WORD, 32'h0, 0);
    add_xfer(1, TRN_NONSEQ, 1, 32'h101, SZ_BYTE, 32'h0000_ab00, 0);   // Lane 1
    add_xfer(1, TRN_NONSEQ, 1, 32'h102, SZ_HALF, 32'hcdef_0000, 0);   // Lanes 3 and 2
    add_xfer(1, TRN_NONSEQ, 0, 32'h100, SZ_WORD, 32'h0, 0);
    add_xfer(1, TRN_NONSEQ, 0, 32'h103, SZ_BYTE, 32'h0, 0);
    // Misaligned, memory must stay untouched
    add_xfer(1, TRN_NONSEQ, 1, 32'h101, SZ_HALF, 32'hffff_ffff, 1);
    add_xfer(1, TRN_NONSEQ, 0, 32'h102, SZ_WORD, 32'h0, 1);
    add_xfer(1, TRN_NONSEQ, 1, 32'h103, SZ_WORD, 32'hffff_ffff, 1);
    add_xfer(1, TRN_NONSEQ, 0, 32'h100, SZ_WORD, 32'h0, 0);
    // No external access for these
    add_xfer(1, TRN_IDLE, 1, 32'h100, SZ_WORD, 32'h5555_5555, 0);
    add_xfer(1, TRN_BUSY, 1, 32'h100, SZ_WORD, 32'h5555_5555, 0);
    add_xfer(0, TRN_NONSEQ, 1, 32'h100, SZ_WORD, 32'h5555_5555, 0);
    add_xfer(1, TRN_NONSEQ, 0, 32'h100, SZ_WORD, 32'h0, 0);
    add_xfer(1, TRN_NONSEQ, 0, 32'h7ffe, SZ_HALF, 32'h0, 0);           // Fill pattern
    // Back to back, random data
    for (int i = 0; i < 6; i++)
    begin
      r = $random(seed);
      add_xfer(1, TRN_NONSEQ, 1, 32'h200 + 8 * i, SZ_WORD, r, 0);
      add_xfer(1, TRN_NONSEQ, 1, 32'h200 + 8 * i + 2, SZ_HALF, ~r, 0);
      add_xfer(1, TRN_NONSEQ, 0, 32'h200 + 8 * i, SZ_WORD, 32'h0, 0);
      add_xfer(1, TRN_NONSEQ, 0, 32'h200 + 8 * i + 3, SZ_BYTE, 32'h0, 0);
    end
  endtask

  // ------------------------------
  // AHB driver
  // ------------------------------
  task automatic drive_addr(input xfer_t e);
    hsel    = e.sel;
    htrans  = e.trans;
    hwrite  = e.write;
    haddr   = e.addr;
    hsize   = e.size;
    exp_err = e.exp_err;
  endtask

  // Returns just after the edge that takes the address phase
  task automatic wait_ready(input int idx, output logic ok);
    int cycles;
    cycles = 0;
    @(negedge hclk4);
    while (!smc_hready && (cycles < READY_TIMEOUT))
    begin
      cycles++;
      @(negedge hclk4);
    end
    ok = smc_hready;
    if (ok)
      @(posedge hclk4);
    else
      $display("Timeout waiting for smc_hready, %0d cycles at entry %0d", cycles, idx);
  endtask

  initial
  begin : main
    logic        ok;
    logic        timed_out;
    int unsigned total_err;
    seed         = 32'h90d4fa7e;
    n_sys_reset4 = 1'b0;
    hsel         = 1'b0;
    htrans       = TRN_IDLE;
    hwrite       = 1'b0;
    haddr        = 32'h0;
    hsize        = SZ_BYTE;
    hwdata       = 32'h0;
    exp_err      = 1'b0;
    timed_out    = 1'b0;
    build_table();
    repeat (3) @(posedge hclk4);
    #1 n_sys_reset4 = 1'b1;
    @(posedge hclk4);
    #1;
    for (int i = 0; i < xfer_tab.size(); i++)
    begin
      drive_addr(xfer_tab[i]);
      wait_ready(i, ok);
      if (!ok)
      begin
        timed_out = 1'b1;
        break;
      end
      #1;
      if (xfer_tab[i].write)
        hwdata = xfer_tab[i].wdata;   // Data phase of this entry
    end
    // Idle cycles let the last data phase complete
    repeat (2)
    begin
      if (!timed_out)
      begin
        drive_addr(IDLE_XFER);
        wait_ready(xfer_tab.size(), ok);
        timed_out = !ok;
        #1;
      end
    end
    total_err = err_cnt + smc_top_i.smc_asserts_i.fail_cnt;
    $display("Checks: %0d, errors: %0d, assertion failures: %0d, timeouts: %0d",
             chk_cnt, err_cnt, smc_top_i.smc_asserts_i.fail_cnt, timed_out);
    if ((total_err == 0) && !timed_out)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
logic/smc_pkg.sv
logic/smc_ahb_lite_if.sv
logic/smc_access_seq.sv
logic/smc_mac.sv
logic/smc_top.sv
tb/smc_checker.sv
tb/smc_asserts.sv
tb/tb_smc.sv

/* Bender.yml */
package:
  name: smc

sources:
  - logic/smc_pkg.sv
  - logic/smc_ahb_lite_if.sv
  - logic/smc_access_seq.sv
  - logic/smc_mac.sv
  - logic/smc_top.sv
  - target: simulation
    files:
      - tb/smc_checker.sv
      - tb/smc_asserts.sv
      - tb/tb_smc.sv
